// File: tb.f
source/ex_pkg.sv
source/alu.sv
source/operand_select.sv
source/store_format.sv
source/fu_alu.sv
source/store_queue.sv
source/ex_alu_top.sv
dv/tb_ex_alu.sv

// File: run.sh
#!/bin/sh
# build and run the alu execute unit testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module tb_ex_alu -Mdir obj_dir -f tb.f \
	|| { echo "verilator build failed"; exit 1; }

./obj_dir/Vtb_ex_alu > sim.log 2>&1
cat sim.log

grep -qxF 'All tests passed!' sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: dv/tb_ex_alu.sv
// alu execute unit testbench

`timescale 1ns/1ns

module tb_ex_alu;

	localparam int sq_depth   = 8;
	localparam int idx_bits   = $clog2(sq_depth);
	localparam int n_random   = 8;   // per alu function
	localparam int n_select   = 40;
	localparam int n_stall    = 60;
	localparam int n_issue    = 10 * n_random + 8 + n_select + n_stall + 11;
	// a store with its read and free takes about five cycles
	localparam int timeout_ns = 4 * (16 + 5 * n_issue + 4 * n_stall + 100);

	logic                         clock, reset, in_valid, halt, complete_stall, free_valid;
	logic [ex_pkg::func_bits-1:0] func;
	logic [1:0]                   opa_select;
	logic [2:0]                   opb_select;
	logic [ex_pkg::xlen-1:0]      pc, npc, inst, rs1_value, rs2_value;
	logic [ex_pkg::pr_bits-1:0]   dest_pr, out_dest_pr;
	logic [ex_pkg::rob_bits-1:0]  rob_entry, out_rob_entry;
	logic [idx_bits-1:0]          sq_idx, free_idx, rd_idx;
	logic                         ready, want_to_complete, out_valid, out_halt, out_take_branch;
	logic [ex_pkg::xlen-1:0]      out_value, rd_addr, rd_data;
	logic                         rd_valid;
	logic [3:0]                   rd_bytes;

	ex_alu_top #(.sq_depth(sq_depth)) u_ex_alu_top (.*);

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] model_opa(input logic [1:0] sel, input logic [31:0] p, np, r1);
		case (sel)
			ex_pkg::opa_rs1: return r1;
			ex_pkg::opa_npc: return np;
			ex_pkg::opa_pc:  return p;
			default:         return 32'h0;
		endcase
	endfunction

	// immediates straight from the rv32 bit layouts
	function automatic logic [31:0] model_opb(input logic [2:0] sel, input logic [31:0] w, r2);
		case (sel)
			ex_pkg::opb_rs2:   return r2;
			ex_pkg::opb_i_imm: return {{21{w[31]}}, w[30:20]};
			ex_pkg::opb_s_imm: return {{21{w[31]}}, w[30:25], w[11:7]};
			ex_pkg::opb_b_imm: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			ex_pkg::opb_u_imm: return {w[31:12], 12'h000};
			ex_pkg::opb_j_imm: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			default:           return ex_pkg::poison_b;
		endcase
	endfunction

	function automatic logic [31:0] model_alu(input logic [3:0] f, input logic [31:0] a, b);
		if (f >= ex_pkg::op_sb)
			return a + b;  // store address
		case (f)
			ex_pkg::alu_add:  return a + b;
			ex_pkg::alu_sub:  return a - b;
			ex_pkg::alu_and:  return a & b;
			ex_pkg::alu_or:   return a | b;
			ex_pkg::alu_xor:  return a ^ b;
			ex_pkg::alu_slt:  return {31'b0, $signed(a) < $signed(b)};
			ex_pkg::alu_sltu: return {31'b0, a < b};
			ex_pkg::alu_srl:  return a >> b[4:0];
			ex_pkg::alu_sll:  return a << b[4:0];
			ex_pkg::alu_sra:  return $signed(a) >>> b[4:0];
			default:          return ex_pkg::poison_a;
		endcase
	endfunction

	function automatic logic [3:0] model_bytes(input logic [3:0] f, input logic [1:0] off);
		case (f)
			ex_pkg::op_sb: return 4'b0001 << off;
			ex_pkg::op_sh: return (off == 2'd0) ? 4'b0011 : ((off == 2'd2) ? 4'b1100 : 4'b0000);
			ex_pkg::op_sw: return 4'b1111;
			default:       return 4'b0000;
		endcase
	endfunction

	// halfword moves up and a byte stays in its own lane
	function automatic logic [31:0] model_data(input logic [3:0] f, input logic [3:0] be,
		input logic [1:0] off, input logic [31:0] v);
		logic [31:0] mask;
		mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
		return (f == ex_pkg::op_sh) ? ((v << (8 * off)) & mask) : (v & mask);
	endfunction

	logic [31:0] exp_opa, exp_opb, exp_value, exp_addr, exp_data;
	logic [3:0]  exp_bytes;
	logic        accepted, is_store;

	always_comb begin
		exp_opa   = model_opa(opa_select, pc, npc, rs1_value);
		exp_opb   = model_opb(opb_select, inst, rs2_value);
		exp_value = model_alu(func, exp_opa, exp_opb);
		exp_addr  = {exp_value[31:2], 2'b00};
		exp_bytes = model_bytes(func, exp_value[1:0]);
		exp_data  = model_data(func, exp_bytes, exp_value[1:0], rs2_value);
	end

	assign accepted = in_valid && !complete_stall;
	assign is_store = accepted && (func >= ex_pkg::op_sb);

	// one cycle copies lined up with the registered outputs
	logic                        prev_accepted, prev_stall, prev_in_valid, prev_reset, prev_halt;
	logic [31:0]                 prev_value, held_value;
	logic                        held_valid;
	logic [ex_pkg::pr_bits+ex_pkg::rob_bits:0] held_tags;  // dest_pr, rob_entry, halt
	logic [ex_pkg::pr_bits-1:0]  prev_dest_pr;
	logic [ex_pkg::rob_bits-1:0] prev_rob;
	logic [sq_depth-1:0]         m_valid;  // queue model
	logic [31:0]                 m_addr  [sq_depth];
	logic [31:0]                 m_data  [sq_depth];
	logic [3:0]                  m_bytes [sq_depth];

	always @(posedge clock) begin
		prev_accepted <= accepted;
		prev_stall    <= complete_stall;
		prev_in_valid <= in_valid;
		prev_reset    <= reset;
		prev_value    <= exp_value;
		prev_dest_pr  <= dest_pr;
		prev_rob      <= rob_entry;
		prev_halt     <= halt;
		held_value    <= out_value;
		held_valid    <= out_valid;
		held_tags     <= {out_dest_pr, out_rob_entry, out_halt};
		if (reset) begin
			m_valid <= '0;
		end else begin
			if (free_valid)
				m_valid[free_idx] <= 1'b0;
			if (is_store) begin  // write after free so the write wins
				m_valid[sq_idx] <= 1'b1;
				m_addr[sq_idx]  <= exp_addr;
				m_data[sq_idx]  <= exp_data;
				m_bytes[sq_idx] <= exp_bytes;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////
	int errors, errors_seen, tests_run;

	task automatic report_mismatch(input string name, input logic [31:0] got, input logic [31:0] want);
		errors++;
		$display("mismatch at %0t ns: %s got %h, expected %h", $time, name, got, want);
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("error at %0t ns: %s", $time, what);
	endtask

	a_out_value: assert property (@(posedge clock) disable iff (reset)
		prev_accepted |-> out_value == prev_value)
		else report_mismatch("out_value", $sampled(out_value), $sampled(prev_value));
	a_out_dest_pr: assert property (@(posedge clock) disable iff (reset)
		prev_accepted |-> out_dest_pr == prev_dest_pr)
		else report_mismatch("out_dest_pr", 32'($sampled(out_dest_pr)), 32'($sampled(prev_dest_pr)));
	a_out_rob_entry: assert property (@(posedge clock) disable iff (reset)
		prev_accepted |-> out_rob_entry == prev_rob)
		else report_mismatch("out_rob_entry", 32'($sampled(out_rob_entry)), 32'($sampled(prev_rob)));
	a_out_halt: assert property (@(posedge clock) disable iff (reset)
		prev_accepted |-> out_halt == prev_halt)
		else report_mismatch("out_halt", 32'($sampled(out_halt)), 32'($sampled(prev_halt)));
	a_out_valid: assert property (@(posedge clock) disable iff (reset)
		!prev_stall |-> out_valid == prev_in_valid)  // catches lost or doubled items
		else report_mismatch("out_valid", 32'($sampled(out_valid)), 32'($sampled(prev_in_valid)));
	a_hold: assert property (@(posedge clock) disable iff (reset)
		prev_stall |-> out_value == held_value && out_valid == held_valid
			&& {out_dest_pr, out_rob_entry, out_halt} == held_tags)
		else report_failure("completion packet changed while complete_stall was high");
	a_ready: assert property (@(posedge clock) disable iff (reset) ready == !complete_stall)
		else report_mismatch("ready", 32'($sampled(ready)), 32'(!$sampled(complete_stall)));
	a_want: assert property (@(posedge clock) disable iff (reset) want_to_complete == in_valid)
		else report_mismatch("want_to_complete", 32'($sampled(want_to_complete)),
			32'($sampled(in_valid)));
	a_no_branch: assert property (@(posedge clock) disable iff (reset) !out_take_branch)
		else report_failure("out_take_branch went high");
	a_reset_clear: assert property (@(posedge clock) disable iff (reset)
		prev_reset |-> !out_valid && out_value == '0)
		else report_failure("completion register not cleared by reset");
	a_rd_valid: assert property (@(posedge clock) disable iff (reset) rd_valid == m_valid[rd_idx])
		else report_mismatch("rd_valid", 32'($sampled(rd_valid)), 32'($sampled(m_valid[rd_idx])));
	a_rd_addr: assert property (@(posedge clock) disable iff (reset)
		m_valid[rd_idx] |-> rd_addr == m_addr[rd_idx])
		else report_mismatch("rd_addr", $sampled(rd_addr), $sampled(m_addr[rd_idx]));
	a_rd_data: assert property (@(posedge clock) disable iff (reset)
		m_valid[rd_idx] |-> rd_data == m_data[rd_idx])
		else report_mismatch("rd_data", $sampled(rd_data), $sampled(m_data[rd_idx]));
	a_rd_bytes: assert property (@(posedge clock) disable iff (reset)
		m_valid[rd_idx] |-> rd_bytes == m_bytes[rd_idx])
		else report_mismatch("rd_bytes", 32'($sampled(rd_bytes)), 32'($sampled(m_bytes[rd_idx])));

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////
	logic [31:0] rob_count;

	// holds the instruction until the unit takes it
	task automatic issue(input logic [3:0] f, input logic [1:0] asel, input logic [2:0] bsel,
		input logic [31:0] word, a, b, input logic [idx_bits-1:0] idx, input bit stalls);
		logic [31:0] r;
		r = $urandom;
		@(negedge clock);
		in_valid       = 1'b1;
		free_valid     = 1'b0;
		func           = f;
		opa_select     = asel;
		opb_select     = bsel;
		inst           = word;
		rs1_value      = a;
		rs2_value      = b;
		sq_idx         = idx;
		pc             = $urandom;
		npc            = pc + 32'd4;
		dest_pr        = r[ex_pkg::pr_bits-1:0];
		halt           = r[31];
		rob_entry      = rob_count[ex_pkg::rob_bits-1:0];  // unique per run of 32
		complete_stall = stalls && (r[9:8] == 2'b00);
		rob_count      = rob_count + 32'd1;
		@(posedge clock);
		while (complete_stall) begin
			@(negedge clock);
			r              = $urandom;
			complete_stall = (r[1:0] == 2'b00);
			@(posedge clock);
		end
	endtask

	task automatic idle(input int n);
		@(negedge clock);
		in_valid       = 1'b0;
		complete_stall = 1'b0;
		free_valid     = 1'b0;
		repeat (n) @(posedge clock);
	endtask

	task automatic read_entry(input logic [idx_bits-1:0] idx);
		@(negedge clock);
		in_valid   = 1'b0;
		free_valid = 1'b0;
		rd_idx     = idx;
		@(posedge clock);  // read port checked here
	endtask

	task automatic free_entry(input logic [idx_bits-1:0] idx);
		@(negedge clock);
		in_valid   = 1'b0;
		free_valid = 1'b1;
		free_idx   = idx;
		@(posedge clock);
	endtask

	// address is rs1 + s_imm and its low bits give the lane offset
	task automatic store_op(input logic [3:0] f, input logic [1:0] off,
		input logic [idx_bits-1:0] idx);
		ex_pkg::rv32_inst word;
		logic [31:0]      r;
		logic [31:0]      base;
		logic [11:0]      imm;
		word = $urandom;
		r    = $urandom;
		base = {r[31:2], 2'b00};
		imm  = {r[13:4], off};
		word.s_fmt.imm_hi = imm[11:5];
		word.s_fmt.imm_lo = imm[4:0];
		issue(f, ex_pkg::opa_rs1, ex_pkg::opb_s_imm, word, base, $urandom, idx, 1'b0);
		read_entry(idx);
	endtask

	function automatic logic [idx_bits-1:0] pick_free();
		logic [31:0] r;
		r = $urandom;
		while (m_valid[r[idx_bits-1:0]])
			r = r + 32'd1;
		return r[idx_bits-1:0];
	endfunction

	task automatic finish_test(input string name);
		idle(2);  // let the last completion reach the checks
		$display("test %s done, %0d errors", name, errors - errors_seen);
		errors_seen = errors;
		tests_run++;
	endtask

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial begin
		#(timeout_ns);
		$display("watchdog expired after %0d ns, run did not complete", timeout_ns);
		$display("Test failures found");
		$finish;
	end

	initial begin
		logic [31:0]         r;
		logic [idx_bits-1:0] idx;
		void'($urandom(32'h16ae_7502));
		reset = 1'b1;
		{in_valid, halt, complete_stall, free_valid} = '0;
		{func, opa_select, opb_select} = '0;
		{pc, npc, inst, rs1_value, rs2_value} = '0;
		{dest_pr, rob_entry, sq_idx, free_idx, rd_idx} = '0;
		{errors, errors_seen, tests_run} = '0;
		rob_count = '0;
		repeat (16) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		for (int i = 0; i < sq_depth; i++)
			read_entry(i[idx_bits-1:0]);
		finish_test("reset");

		for (int f = 0; f < 10; f++)
			repeat (n_random)
				issue(f[3:0], ex_pkg::opa_rs1, ex_pkg::opb_rs2, $urandom, $urandom, $urandom, '0, 1'b0);
		// signed against unsigned compares and shift extremes
		issue(ex_pkg::alu_slt, ex_pkg::opa_rs1, ex_pkg::opb_rs2, '0, 32'h8000_0000, 32'h1, '0, 1'b0);
		issue(ex_pkg::alu_sltu, ex_pkg::opa_rs1, ex_pkg::opb_rs2, '0, 32'h8000_0000, 32'h1, '0, 1'b0);
		issue(ex_pkg::alu_slt, ex_pkg::opa_rs1, ex_pkg::opb_rs2, '0, 32'h1, 32'hffff_ffff, '0, 1'b0);
		issue(ex_pkg::alu_sltu, ex_pkg::opa_rs1, ex_pkg::opb_rs2, '0, 32'h1, 32'hffff_ffff, '0, 1'b0);
		issue(ex_pkg::alu_srl, ex_pkg::opa_rs1, ex_pkg::opb_rs2, '0, 32'h8000_0001, 32'd0, '0, 1'b0);
		issue(ex_pkg::alu_sll, ex_pkg::opa_rs1, ex_pkg::opb_rs2, '0, 32'h8000_0001, 32'd31, '0, 1'b0);
		issue(ex_pkg::alu_sra, ex_pkg::opa_rs1, ex_pkg::opb_rs2, '0, 32'h8000_0001, 32'd31, '0, 1'b0);
		issue(ex_pkg::alu_sra, ex_pkg::opa_rs1, ex_pkg::opb_rs2, '0, 32'h8000_0001, 32'd0, '0, 1'b0);
		finish_test("alu");

		repeat (n_select) begin
			r = $urandom;  // opb codes 6 and 7 land on the poison value
			issue(ex_pkg::alu_add, r[1:0], (r[4:2] == 3'd0) ? ex_pkg::opb_j_imm : r[4:2],
				$urandom, $urandom, $urandom, '0, 1'b0);
		end
		finish_test("select");

		repeat (n_stall) begin
			r = $urandom;
			issue(r[3:0] % 4'd10, r[5:4], {1'b0, r[7:6]}, $urandom, $urandom, $urandom, '0, 1'b1);
		end
		finish_test("stall");

		for (int off = 0; off < 4; off++) begin
			idx = pick_free();
			store_op(ex_pkg::op_sb, off[1:0], idx);
			free_entry(idx);
			idx = pick_free();
			store_op(ex_pkg::op_sh, off[1:0], idx);  // odd offsets give no lanes
			free_entry(idx);
		end
		r   = $urandom;
		idx = pick_free();
		store_op(ex_pkg::op_sw, r[1:0], idx);
		free_entry(idx);
		finish_test("stores");

		idx = pick_free();
		store_op(ex_pkg::op_sw, 2'd0, idx);
		free_entry(idx);
		read_entry(idx);  // freed entry reads invalid
		store_op(ex_pkg::op_sh, 2'd2, idx);
		free_entry(idx);
		read_entry(idx);
		finish_test("reuse");

		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: source/ex_alu_top.sv
// alu execute unit with store queue

`timescale 1ns/1ns

module ex_alu_top #(
	parameter int sq_depth = 8
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          in_valid,
	input  logic [ex_pkg::func_bits-1:0]  func,
	input  logic [1:0]                    opa_select,
	input  logic [2:0]                    opb_select,
	input  logic [ex_pkg::xlen-1:0]       pc,
	input  logic [ex_pkg::xlen-1:0]       npc,
	input  logic [ex_pkg::xlen-1:0]       inst,
	input  logic [ex_pkg::xlen-1:0]       rs1_value,
	input  logic [ex_pkg::xlen-1:0]       rs2_value,
	input  logic [ex_pkg::pr_bits-1:0]    dest_pr,
	input  logic [ex_pkg::rob_bits-1:0]   rob_entry,
	input  logic                          halt,
	input  logic [$clog2(sq_depth)-1:0]   sq_idx,
	output logic                          ready,
	input  logic                          complete_stall,
	output logic                          want_to_complete,
	output logic                          out_valid,
	output logic [ex_pkg::xlen-1:0]       out_value,
	output logic [ex_pkg::pr_bits-1:0]    out_dest_pr,
	output logic [ex_pkg::rob_bits-1:0]   out_rob_entry,
	output logic                          out_halt,
	output logic                          out_take_branch,
	input  logic                          free_valid,
	input  logic [$clog2(sq_depth)-1:0]   free_idx,
	input  logic [$clog2(sq_depth)-1:0]   rd_idx,
	output logic                          rd_valid,
	output logic [ex_pkg::xlen-1:0]       rd_addr,
	output logic [ex_pkg::xlen-1:0]       rd_data,
	output logic [3:0]                    rd_bytes
);

	// unit to queue
	logic                         sq_write;
	logic [$clog2(sq_depth)-1:0]  st_idx;
	logic [ex_pkg::xlen-1:0]      st_addr;
	logic [ex_pkg::xlen-1:0]      st_data;
	logic [3:0]                   st_bytes;

	fu_alu #(.sq_depth(sq_depth)) u_fu_alu (
		.clock            (clock),
		.reset            (reset),
		.in_valid         (in_valid),
		.func             (func),
		.opa_select       (opa_select),
		.opb_select       (opb_select),
		.pc               (pc),
		.npc              (npc),
		.inst             (inst),
		.rs1_value        (rs1_value),
		.rs2_value        (rs2_value),
		.dest_pr          (dest_pr),
		.rob_entry        (rob_entry),
		.halt             (halt),
		.sq_idx           (sq_idx),
		.ready            (ready),
		.complete_stall   (complete_stall),
		.want_to_complete (want_to_complete),
		.out_valid        (out_valid),
		.out_value        (out_value),
		.out_dest_pr      (out_dest_pr),
		.out_rob_entry    (out_rob_entry),
		.out_halt         (out_halt),
		.out_take_branch  (out_take_branch),
		.sq_write         (sq_write),
		.st_idx           (st_idx),
		.st_addr          (st_addr),
		.st_data          (st_data),
		.st_bytes         (st_bytes)
	);

	store_queue #(.sq_depth(sq_depth)) u_store_queue (
		.clock      (clock),
		.reset      (reset),
		.sq_write   (sq_write),
		.sq_idx     (st_idx),
		.st_addr    (st_addr),
		.st_data    (st_data),
		.st_bytes   (st_bytes),
		.free_valid (free_valid),
		.free_idx   (free_idx),
		.rd_idx     (rd_idx),
		.rd_valid   (rd_valid),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data),
		.rd_bytes   (rd_bytes)
	);

endmodule

// File: source/store_queue.sv
// store queue entries

`timescale 1ns/1ns

module store_queue #(
	parameter int sq_depth = 8
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          sq_write,
	input  logic [$clog2(sq_depth)-1:0]   sq_idx,
	input  logic [ex_pkg::xlen-1:0]       st_addr,
	input  logic [ex_pkg::xlen-1:0]       st_data,
	input  logic [3:0]                    st_bytes,
	input  logic                          free_valid,
	input  logic [$clog2(sq_depth)-1:0]   free_idx,
	input  logic [$clog2(sq_depth)-1:0]   rd_idx,
	output logic                          rd_valid,
	output logic [ex_pkg::xlen-1:0]       rd_addr,
	output logic [ex_pkg::xlen-1:0]       rd_data,
	output logic [3:0]                    rd_bytes
);

	logic [sq_depth-1:0]          entry_valid;
	logic [ex_pkg::xlen-1:0]      entry_addr  [sq_depth];
	logic [ex_pkg::xlen-1:0]      entry_data  [sq_depth];
	logic [3:0]                   entry_bytes [sq_depth];

	// valid bits, free first so a same-index write wins
	always_ff @(posedge clock) begin
		if (reset) begin
			entry_valid <= '0;
		end else begin
			if (free_valid)
				entry_valid[free_idx] <= 1'b0;
			if (sq_write)
				entry_valid[sq_idx] <= 1'b1;
		end
	end

	// payload, meaningful only under entry_valid
	always_ff @(posedge clock) begin
		if (sq_write) begin
			entry_addr[sq_idx]  <= st_addr;
			entry_data[sq_idx]  <= st_data;
			entry_bytes[sq_idx] <= st_bytes;
		end
	end

	////////////////////////////////////////////////////////////
	// read port, combinational from rd_idx
	////////////////////////////////////////////////////////////
	assign rd_valid = entry_valid[rd_idx];
	assign rd_addr  = entry_addr[rd_idx];
	assign rd_data  = entry_data[rd_idx];
	assign rd_bytes = entry_bytes[rd_idx];

	// issue must hand out a free slot, a free in the same cycle counts
	a_no_overwrite: assert property (
		@(posedge clock) disable iff (reset)
		sq_write |-> (!entry_valid[sq_idx] || (free_valid && free_idx == sq_idx))
	) else $error("store_queue: write to live entry %0d", sq_idx);

endmodule

// File: source/fu_alu.sv
// alu functional unit

`timescale 1ns/1ns

module fu_alu #(
	parameter int sq_depth = 8
) (
	input  logic                             clock,
	input  logic                             reset,
	// issue side
	input  logic                             in_valid,
	input  logic [ex_pkg::func_bits-1:0]     func,
	input  logic [1:0]                       opa_select,
	input  logic [2:0]                       opb_select,
	input  logic [ex_pkg::xlen-1:0]          pc,
	input  logic [ex_pkg::xlen-1:0]          npc,
	input  logic [ex_pkg::xlen-1:0]          inst,
	input  logic [ex_pkg::xlen-1:0]          rs1_value,
	input  logic [ex_pkg::xlen-1:0]          rs2_value,
	input  logic [ex_pkg::pr_bits-1:0]       dest_pr,
	input  logic [ex_pkg::rob_bits-1:0]      rob_entry,
	input  logic                             halt,
	input  logic [$clog2(sq_depth)-1:0]      sq_idx,
	output logic                             ready,
	// complete side
	input  logic                             complete_stall,
	output logic                             want_to_complete,
	output logic                             out_valid,
	output logic [ex_pkg::xlen-1:0]          out_value,
	output logic [ex_pkg::pr_bits-1:0]       out_dest_pr,
	output logic [ex_pkg::rob_bits-1:0]      out_rob_entry,
	output logic                             out_halt,
	output logic                             out_take_branch,
	// store side
	output logic                             sq_write,
	output logic [$clog2(sq_depth)-1:0]      st_idx,
	output logic [ex_pkg::xlen-1:0]          st_addr,
	output logic [ex_pkg::xlen-1:0]          st_data,
	output logic [3:0]                       st_bytes
);

	logic                          is_store;
	logic [ex_pkg::func_bits-1:0]  alu_func;
	logic [ex_pkg::xlen-1:0]       opa;
	logic [ex_pkg::xlen-1:0]       opb;
	logic [ex_pkg::xlen-1:0]       alu_result;

	// store codes sit above every alu code
	assign is_store = in_valid && (func >= ex_pkg::op_sb);
	assign alu_func = is_store ? ex_pkg::alu_add : func;  // address is rs1 + s_imm

	assign ready            = ~complete_stall;
	assign want_to_complete = in_valid;
	assign sq_write         = is_store && !complete_stall;  // only on acceptance
	assign st_idx           = sq_idx;                       // slot from issue

	operand_select u_operand_select (
		.opa_select (opa_select),
		.opb_select (opb_select),
		.pc         (pc),
		.npc        (npc),
		.rs1_value  (rs1_value),
		.rs2_value  (rs2_value),
		.inst       (inst),
		.opa        (opa),
		.opb        (opb)
	);

	alu u_alu (
		.clock  (clock),
		.opa    (opa),
		.opb    (opb),
		.func   (alu_func),
		.result (alu_result)
	);

	store_format u_store_format (
		.func        (func),
		.addr_sum    (alu_result),
		.store_value (rs2_value),  // data always from rs2
		.st_addr     (st_addr),
		.st_data     (st_data),
		.st_bytes    (st_bytes)
	);

	////////////////////////////////////////////////////////////
	// completion register held while the complete stage stalls
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid       <= 1'b0;
			out_value       <= '0;
			out_dest_pr     <= '0;
			out_rob_entry   <= '0;
			out_halt        <= 1'b0;
			out_take_branch <= 1'b0;
		end else if (!complete_stall) begin
			out_valid       <= in_valid;
			out_value       <= alu_result;  // address for a store
			out_dest_pr     <= dest_pr;
			out_rob_entry   <= rob_entry;
			out_halt        <= halt;
			out_take_branch <= 1'b0;        // no branch resolution here
		end
	end

	a_sq_idx_range: assert property (
		@(posedge clock) disable iff (reset) sq_write |-> (st_idx < sq_depth)
	) else $error("fu_alu: store index %0d out of range", st_idx);

endmodule

// File: source/store_format.sv
// store lane formatting

`timescale 1ns/1ns

module store_format (
	input  logic [ex_pkg::func_bits-1:0] func,
	input  logic [ex_pkg::xlen-1:0]      addr_sum,
	input  logic [ex_pkg::xlen-1:0]      store_value,
	output logic [ex_pkg::xlen-1:0]      st_addr,
	output logic [ex_pkg::xlen-1:0]      st_data,
	output logic [3:0]                   st_bytes
);

	logic [1:0] offset;  // byte within the word

	assign offset  = addr_sum[1:0];
	assign st_addr = {addr_sum[ex_pkg::xlen-1:2], 2'b00};

	always_comb begin
		st_bytes = 4'b0000;  // disabled lanes stay zero
		st_data  = '0;
		case (func)
			// byte keeps the value's own lane
			ex_pkg::op_sb: begin
				st_bytes                 = 4'b0001 << offset;
				st_data[8*offset +: 8]   = store_value[8*offset +: 8];
			end
			ex_pkg::op_sh: begin
				case (offset)
					2'b00: begin
						st_bytes       = 4'b0011;
						st_data[15:0]  = store_value[15:0];
					end
					2'b10: begin
						st_bytes       = 4'b1100;
						st_data[31:16] = store_value[15:0];  // low half moved up
					end
					default: begin
						// misaligned half, nothing enabled
						st_bytes = 4'b0000;
					end
				endcase
			end
			ex_pkg::op_sw: begin
				st_bytes = 4'b1111;
				st_data  = store_value;
			end
			default: begin
				st_bytes = 4'b0000;  // not a store
			end
		endcase
	end

endmodule

// File: source/operand_select.sv
// alu operand multiplexers

`timescale 1ns/1ns

module operand_select (
	input  logic [1:0]              opa_select,
	input  logic [2:0]              opb_select,
	input  logic [ex_pkg::xlen-1:0] pc,
	input  logic [ex_pkg::xlen-1:0] npc,
	input  logic [ex_pkg::xlen-1:0] rs1_value,
	input  logic [ex_pkg::xlen-1:0] rs2_value,
	input  logic [ex_pkg::xlen-1:0] inst,
	output logic [ex_pkg::xlen-1:0] opa,
	output logic [ex_pkg::xlen-1:0] opb
);

	ex_pkg::rv32_inst               word;
	logic [ex_pkg::xlen-1:0]        i_imm;
	logic [ex_pkg::xlen-1:0]        s_imm;
	logic [ex_pkg::xlen-1:0]        b_imm;
	logic [ex_pkg::xlen-1:0]        u_imm;
	logic [ex_pkg::xlen-1:0]        j_imm;

	assign word = inst;

	////////////////////////////////////////////////////////////
	// immediates, all sign extended from bit 31
	////////////////////////////////////////////////////////////
	assign i_imm = {{20{word.i_fmt.imm[11]}}, word.i_fmt.imm};
	assign s_imm = {{20{word.s_fmt.imm_hi[6]}}, word.s_fmt.imm_hi, word.s_fmt.imm_lo};
	assign b_imm = {{19{word.b_fmt.imm12}}, word.b_fmt.imm12, word.b_fmt.imm11,
		word.b_fmt.imm10_5, word.b_fmt.imm4_1, 1'b0};  // halfword aligned
	assign u_imm = {word.u_fmt.imm, 12'b0};              // upper 20, low bits clear
	assign j_imm = {{11{word.j_fmt.imm20}}, word.j_fmt.imm20, word.j_fmt.imm19_12,
		word.j_fmt.imm11, word.j_fmt.imm10_1, 1'b0};

	// operand a, all four codes legal
	always_comb begin
		opa = ex_pkg::poison_a;
		case (opa_select)
			ex_pkg::opa_rs1:  opa = rs1_value;
			ex_pkg::opa_npc:  opa = npc;
			ex_pkg::opa_pc:   opa = pc;
			ex_pkg::opa_zero: opa = '0;
		endcase
	end

	// operand b
	always_comb begin
		case (opb_select)
			ex_pkg::opb_rs2:   opb = rs2_value;
			ex_pkg::opb_i_imm: opb = i_imm;
			ex_pkg::opb_s_imm: opb = s_imm;
			ex_pkg::opb_b_imm: opb = b_imm;
			ex_pkg::opb_u_imm: opb = u_imm;
			ex_pkg::opb_j_imm: opb = j_imm;
			default:           opb = ex_pkg::poison_b;  // codes 6 and 7
		endcase
	end

endmodule

// File: source/alu.sv
// integer alu

`timescale 1ns/1ns

module alu (
	input  logic                         clock,  // assertion sampling only
	input  logic [ex_pkg::xlen-1:0]      opa,
	input  logic [ex_pkg::xlen-1:0]      opb,
	input  logic [ex_pkg::func_bits-1:0] func,
	output logic [ex_pkg::xlen-1:0]      result
);

	logic signed [ex_pkg::xlen-1:0] signed_opa;
	logic signed [ex_pkg::xlen-1:0] signed_opb;
	logic [4:0]                     shamt;

	assign signed_opa = opa;
	assign signed_opb = opb;
	assign shamt      = opb[4:0];  // rv32 uses only five bits

	always_comb begin
		case (func)
			ex_pkg::alu_add:  result = opa + opb;
			ex_pkg::alu_sub:  result = opa - opb;
			ex_pkg::alu_and:  result = opa & opb;
			ex_pkg::alu_slt:  result = {{(ex_pkg::xlen-1){1'b0}}, signed_opa < signed_opb};
			ex_pkg::alu_sltu: result = {{(ex_pkg::xlen-1){1'b0}}, opa < opb};
			ex_pkg::alu_or:   result = opa | opb;
			ex_pkg::alu_xor:  result = opa ^ opb;
			ex_pkg::alu_srl:  result = opa >> shamt;
			ex_pkg::alu_sll:  result = opa << shamt;
			ex_pkg::alu_sra:  result = signed_opa >>> shamt;  // sign fill
			default:          result = ex_pkg::poison_a;      // undefined code
		endcase
	end

	// shifts and compares depend on a clean code, an X here means
	// the issue side sent garbage through the store override mux
	a_func_known: assert property (
		@(posedge clock) !$isunknown(func)
	) else $error("alu: unknown func %b", func);

endmodule

// File: source/ex_pkg.sv
// execute stage shared definitions

package ex_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////
	localparam int xlen      = 32;
	localparam int pr_bits   = 6;  // physical register tag
	localparam int rob_bits  = 5;  // rob entry tag
	localparam int func_bits = 4;

	// alu function codes, store codes sit above every alu code
	localparam logic [func_bits-1:0] alu_add  = 4'd0;
	localparam logic [func_bits-1:0] alu_sub  = 4'd1;
	localparam logic [func_bits-1:0] alu_and  = 4'd2;
	localparam logic [func_bits-1:0] alu_slt  = 4'd3;
	localparam logic [func_bits-1:0] alu_sltu = 4'd4;
	localparam logic [func_bits-1:0] alu_or   = 4'd5;
	localparam logic [func_bits-1:0] alu_xor  = 4'd6;
	localparam logic [func_bits-1:0] alu_srl  = 4'd7;
	localparam logic [func_bits-1:0] alu_sll  = 4'd8;
	localparam logic [func_bits-1:0] alu_sra  = 4'd9;
	localparam logic [func_bits-1:0] op_sb    = 4'd10; // first store code
	localparam logic [func_bits-1:0] op_sh    = 4'd11;
	localparam logic [func_bits-1:0] op_sw    = 4'd12;

	// operand a select
	localparam logic [1:0] opa_rs1  = 2'd0;
	localparam logic [1:0] opa_npc  = 2'd1;
	localparam logic [1:0] opa_pc   = 2'd2;
	localparam logic [1:0] opa_zero = 2'd3;

	// operand b select, 6 and 7 illegal
	localparam logic [2:0] opb_rs2   = 3'd0;
	localparam logic [2:0] opb_i_imm = 3'd1;
	localparam logic [2:0] opb_s_imm = 3'd2;
	localparam logic [2:0] opb_b_imm = 3'd3;
	localparam logic [2:0] opb_u_imm = 3'd4;
	localparam logic [2:0] opb_j_imm = 3'd5;

	// fill values, easy to spot in a waveform
	localparam logic [xlen-1:0] poison_a = 32'hfacebeec;
	localparam logic [xlen-1:0] poison_b = 32'hfacefeed;

	////////////////////////////////////////////////////////////
	// instruction word, one view per immediate format
	////////////////////////////////////////////////////////////
	typedef union packed {
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_fmt;
		struct packed {
			logic [6:0]  imm_hi;  // imm[11:5]
			logic [4:0]  rs2;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  imm_lo;  // imm[4:0]
			logic [6:0]  opcode;
		} s_fmt;
		struct packed {
			logic        imm12;
			logic [5:0]  imm10_5;
			logic [4:0]  rs2;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [3:0]  imm4_1;
			logic        imm11;
			logic [6:0]  opcode;
		} b_fmt;
		struct packed {
			logic [19:0] imm;     // imm[31:12]
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u_fmt;
		struct packed {
			logic        imm20;
			logic [9:0]  imm10_1;
			logic        imm11;
			logic [7:0]  imm19_12;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} j_fmt;
	} rv32_inst;

endpackage
